// File: rtl/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Architectural word width.
`define DATA_WIDTH 32

// Low bits of operand a that give the shift amount.
`define SHAMT_WIDTH 5

// One restoring step per quotient bit.
`define DIV_STEPS 32

`endif

// File: rtl/aluPkg.sv
`default_nettype none

`include "mips_defines.svh"

package aluPkg;

  typedef logic [`DATA_WIDTH-1:0]   wordT;   // Operands and results.
  typedef logic [2*`DATA_WIDTH-1:0] dwordT;  // Full multiply product.

  typedef enum logic [3:0] {
    OpAdd  = 4'd0,
    OpSub  = 4'd1,
    OpAnd  = 4'd2,
    OpOr   = 4'd3,
    OpSlt  = 4'd4,
    OpDiv  = 4'd5,
    OpMult = 4'd6,
    OpSll  = 4'd7,
    OpXor  = 4'd8,
    OpSra  = 4'd9,
    OpSrl  = 4'd10,
    OpMfhi = 4'd11,  // Reads HI back.
    OpMflo = 4'd12   // Reads LO back.
  } aluOpT;

endpackage

`default_nettype wire

// File: rtl/execPkg.sv
`default_nettype none

package execPkg;

  import aluPkg::*;

  // One operation handed to the execute stage.
  typedef struct packed {
    aluOpT op;
    logic  unsign;
    wordT  a;
    wordT  b;
  } execReqT;

  // Registered answer returned with ack.
  typedef struct packed {
    wordT result;
    wordT hi;
    wordT lo;
    logic eq;
    logic lt;
  } execRespT;

  typedef enum logic [1:0] {
    Idle,     // Waiting for req.
    Wait,     // Multiply or divide in flight.
    Done,     // ALU result being latched.
    Release   // Ack high until req drops.
  } execStateT;

endpackage

`default_nettype wire

// File: rtl/mipsAlu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module mipsAlu import aluPkg::*; (
  input  wordT  a,
  input  wordT  b,
  input  aluOpT op,
  input  logic  unsign,
  output wordT  result,
  output logic  eq,
  output logic  lt
);

  logic [`SHAMT_WIDTH-1:0] shamt;
  logic                    ltCmp;

  assign shamt = a[`SHAMT_WIDTH-1:0];  // Upper bits of a are ignored.

  // Shared by SUB flags and SLT.
  assign ltCmp = unsign ? (a < b) : ($signed(a) < $signed(b));

  always_comb begin
    result = '0;
    eq     = 1'b0;
    lt     = 1'b0;
    case (op)
      OpAdd: begin
        result = a + b;
      end
      OpSub: begin
        result = a - b;
        eq     = (a == b);
        lt     = ltCmp;
      end
      OpAnd: begin
        result = a & b;
      end
      OpOr: begin
        result = a | b;
      end
      OpXor: begin
        result = a ^ b;
      end
      OpSlt: begin
        result = wordT'(ltCmp);
      end
      OpSll: begin
        result = b << shamt;
      end
      OpSrl: begin
        result = b >> shamt;
      end
      OpSra: begin
        result = $signed(b) >>> shamt;  // Sign bit fills from the left.
      end
      OpMult, OpDiv, OpMfhi, OpMflo: begin
        result = '0;  // Controller picks HI/LO for these.
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/mulDivUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module mulDivUnit import aluPkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic start,
  input  logic isDiv,
  input  logic unsign,
  input  wordT a,
  input  wordT b,
  output logic done,
  output wordT hi,
  output wordT lo
);

  typedef logic [$clog2(`DIV_STEPS + 1)-1:0] stepCntT;

  dwordT   aExt;
  dwordT   bExt;
  logic    signA;
  logic    signB;
  wordT    aMag;
  wordT    bMag;
  logic    mulPend;
  logic    divBusy;
  logic    divFix;
  stepCntT stepCnt;
  wordT    remR;
  wordT    quo;
  wordT    divisor;
  logic    qNeg;
  logic    rNeg;
  logic [`DATA_WIDTH:0] shifted;
  logic [`DATA_WIDTH:0] diff;

  assign aExt  = unsign ? {{`DATA_WIDTH{1'b0}}, a} : {{`DATA_WIDTH{a[`DATA_WIDTH-1]}}, a};
  assign bExt  = unsign ? {{`DATA_WIDTH{1'b0}}, b} : {{`DATA_WIDTH{b[`DATA_WIDTH-1]}}, b};
  assign signA = !unsign && a[`DATA_WIDTH-1];
  assign signB = !unsign && b[`DATA_WIDTH-1];
  assign aMag  = signA ? -a : a;
  assign bMag  = signB ? -b : b;

  // Each step shifts in the next dividend bit and tries the subtract.
  assign shifted = {remR, quo[`DATA_WIDTH-1]};
  assign diff    = shifted - {1'b0, divisor};

  always_ff @(posedge clk) begin
    if (!rstN) begin
      mulPend <= 1'b0;
      divBusy <= 1'b0;
      divFix  <= 1'b0;
      stepCnt <= '0;
      done    <= 1'b0;
    end else begin
      done    <= mulPend || divFix;
      mulPend <= start && !isDiv;
      divFix  <= 1'b0;
      if (start && isDiv) begin
        divBusy <= 1'b1;
        stepCnt <= stepCntT'(`DIV_STEPS);
      end else if (divBusy) begin
        stepCnt <= stepCnt - stepCntT'(1);
        if (stepCnt == stepCntT'(1)) begin
          divBusy <= 1'b0;
          divFix  <= 1'b1;  // Sign fix on the next edge.
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start && !isDiv) begin
      {hi, lo} <= aExt * bExt;  // Low 64 bits are exact for both signednesses.
    end else if (start && isDiv) begin
      remR    <= '0;
      quo     <= aMag;
      divisor <= bMag;
      qNeg    <= signA ^ signB;
      rNeg    <= signA;
    end else if (divBusy) begin
      if (!diff[`DATA_WIDTH]) begin
        remR <= diff[`DATA_WIDTH-1:0];
        quo  <= {quo[`DATA_WIDTH-2:0], 1'b1};
      end else begin
        remR <= shifted[`DATA_WIDTH-1:0];
        quo  <= {quo[`DATA_WIDTH-2:0], 1'b0};
      end
    end else if (divFix) begin
      hi <= rNeg ? -remR : remR;  // Remainder follows the dividend.
      lo <= qNeg ? -quo : quo;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) start |-> !(divBusy || divFix))
    else $error("start while a division is busy");

  assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
    else $error("done held longer than one cycle");

endmodule

`default_nettype wire

// File: rtl/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit import aluPkg::*, execPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     req,
  input  execReqT  execReq,
  output logic     ack,
  output execRespT execResp
);

  execStateT state;
  execReqT   reqQ;
  wordT      hiQ;
  wordT      loQ;
  logic      start;
  logic      isMulDiv;
  wordT      aluResult;
  logic      aluEq;
  logic      aluLt;
  logic      mdDone;
  wordT      mdHi;
  wordT      mdLo;
  execRespT  respNext;

  assign isMulDiv = (execReq.op == OpMult) || (execReq.op == OpDiv);

  mipsAlu u_mipsAlu (
    .a      (reqQ.a),
    .b      (reqQ.b),
    .op     (reqQ.op),
    .unsign (reqQ.unsign),
    .result (aluResult),
    .eq     (aluEq),
    .lt     (aluLt)
  );

  mulDivUnit u_mulDivUnit (
    .clk    (clk),
    .rstN   (rstN),
    .start  (start),
    .isDiv  (reqQ.op == OpDiv),
    .unsign (reqQ.unsign),
    .a      (reqQ.a),
    .b      (reqQ.b),
    .done   (mdDone),
    .hi     (mdHi),
    .lo     (mdLo)
  );

  always_comb begin
    respNext.result = aluResult;
    if (reqQ.op == OpMfhi) begin
      respNext.result = hiQ;
    end else if (reqQ.op == OpMflo) begin
      respNext.result = loQ;
    end
    respNext.hi = mdDone ? mdHi : hiQ;  // New pair on the done cycle.
    respNext.lo = mdDone ? mdLo : loQ;
    respNext.eq = aluEq;
    respNext.lt = aluLt;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= Idle;
      ack   <= 1'b0;
      start <= 1'b0;
      hiQ   <= '0;
      loQ   <= '0;
    end else begin
      start <= 1'b0;
      case (state)
        Idle: begin
          if (req) begin
            start <= isMulDiv;
            if (isMulDiv) begin
              state <= Wait;
            end else begin
              state <= Done;
            end
          end
        end
        Wait: begin
          if (mdDone) begin
            hiQ   <= mdHi;
            loQ   <= mdLo;
            ack   <= 1'b1;
            state <= Release;
          end
        end
        Done: begin
          ack   <= 1'b1;
          state <= Release;
        end
        Release: begin
          if (!req) begin  // Held here under back-pressure.
            ack   <= 1'b0;
            state <= Idle;
          end
        end
        default: begin
          state <= Idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == Idle && req) begin
      reqQ <= execReq;
    end
    if (state == Done || (state == Wait && mdDone)) begin
      execResp <= respNext;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) $rose(ack) |-> $past(req))
    else $error("ack rose without a pending req");

  assert property (@(posedge clk) disable iff (!rstN) ack && $past(ack) |-> $stable(execResp))
    else $error("execResp changed while ack was high");

endmodule

`default_nettype wire

// File: tests/execUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module execUnitTb import aluPkg::*, execPkg::*; ();

  localparam int TimeoutCycles = 400 * 40 + 10;  // Transactions times worst length, plus reset.

  logic        clk;
  logic        rstN;
  logic        req;
  logic        ack;
  execReqT     execReq;
  execRespT    execResp;
  int unsigned lcgState = 32'd66404;
  int          cycleCount;
  int          errorCount;
  int          txnCount;
  int          testCount;
  int          errBase;
  int          txnBase;
  wordT        hiModel;
  wordT        loModel;
  string       currentTest;
  execRespT    expQ[$];
  execRespT    actQ[$];
  string       nameQ[$];

  execUnit u_execUnit (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .execReq  (execReq),
    .ack      (ack),
    .execResp (execResp)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > TimeoutCycles) begin
      $display("Timeout after %0d cycles, the DUT stopped answering requests", cycleCount);
      $display("Test failed");
      $finish;
    end
  end

  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  // Mixes extreme operands in with plain random ones.
  function automatic wordT randWord();
    int unsigned r1;
    int unsigned r2;
    wordT        w;
    r1 = nextRand();
    r2 = nextRand();
    case (r1[29:27])
      3'd0:    w = 32'h8000_0000;
      3'd1:    w = 32'hffff_ffff;
      3'd2:    w = '0;
      3'd3:    w = {27'd0, r2[20:16]};
      default: w = {r1[31:16], r2[31:16]};
    endcase
    return w;
  endfunction

  function automatic execRespT refExec(execReqT r, wordT hiIn, wordT loIn);
    execRespT                e;
    logic [`SHAMT_WIDTH-1:0] sh;
    logic                    lessThan;
    logic                    sa;
    logic                    sb;
    longint                  sp;
    dwordT                   magA;
    dwordT                   magB;
    wordT                    q;
    wordT                    rm;
    e = '{result: '0, hi: hiIn, lo: loIn, eq: 1'b0, lt: 1'b0};
    sh = r.a[`SHAMT_WIDTH-1:0];
    // Flipping the sign bit orders signed values as unsigned ones.
    lessThan = r.unsign ? (r.a < r.b) : ((r.a ^ 32'h8000_0000) < (r.b ^ 32'h8000_0000));
    sa = !r.unsign && r.a[31];
    sb = !r.unsign && r.b[31];
    case (r.op)
      OpAdd: e.result = r.a + r.b;
      OpSub: begin
        e.result = r.a - r.b;
        e.eq = (r.a == r.b);
        e.lt = lessThan;
      end
      OpAnd: e.result = r.a & r.b;
      OpOr:  e.result = r.a | r.b;
      OpXor: e.result = r.a ^ r.b;
      OpSlt: e.result = {31'd0, lessThan};
      OpSll: e.result = r.b << sh;
      OpSrl: e.result = r.b >> sh;
      OpSra: e.result = (r.b >> sh) | (r.b[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
      OpMult: begin
        if (r.unsign) begin
          {e.hi, e.lo} = {32'd0, r.a} * {32'd0, r.b};
        end else begin
          sp = longint'($signed(r.a)) * longint'($signed(r.b));
          {e.hi, e.lo} = sp;
        end
      end
      OpDiv: begin
        magA = {32'd0, sa ? -r.a : r.a};
        magB = {32'd0, sb ? -r.b : r.b};
        if (r.b == '0) begin
          q = '1;  // Zero divisor gives all ones and keeps the dividend.
          rm = r.a;
        end else begin
          q = wordT'(magA / magB);
          rm = sa ? -wordT'(magA % magB) : wordT'(magA % magB);
        end
        if (sa ^ sb) q = -q;
        e.hi = rm;
        e.lo = q;
      end
      OpMfhi: e.result = hiIn;
      OpMflo: e.result = loIn;
      default: ;
    endcase
    return e;
  endfunction

  task automatic checkWord(input string testName, input string field,
                           input wordT expected, input wordT actual);
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %s %s: expected %h, actual %h", testName, field, expected, actual);
    end
  endtask

  task automatic checkFlag(input string testName, input string field,
                           input logic expected, input logic actual);
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %s %s: expected %b, actual %b", testName, field, expected, actual);
    end
  endtask

  always @(negedge clk) begin : compareResponses
    execRespT expResp;
    execRespT actResp;
    string    name;
    while (actQ.size() > 0) begin
      expResp = expQ.pop_front();
      actResp = actQ.pop_front();
      name = nameQ.pop_front();
      checkWord(name, "result", expResp.result, actResp.result);
      checkWord(name, "hi", expResp.hi, actResp.hi);
      checkWord(name, "lo", expResp.lo, actResp.lo);
      checkFlag(name, "eq", expResp.eq, actResp.eq);
      checkFlag(name, "lt", expResp.lt, actResp.lt);
    end
  end

  // Called 1 ns after a rising edge, returns 1 ns after one.
  task automatic runTxn(input execReqT r, input int holdExtra);
    execRespT expected;
    execRespT got;
    expected = refExec(r, hiModel, loModel);
    hiModel = expected.hi;
    loModel = expected.lo;
    req = 1'b1;
    execReq = r;
    do begin
      @(posedge clk);
      #1;
    end while (!ack);
    got = execResp;
    repeat (holdExtra) begin
      @(posedge clk);
      #1;
      if (!ack || execResp !== got) begin
        errorCount++;
        $display("%s: ack dropped or the response changed while req was high", currentTest);
      end
    end
    req = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (ack);
    expQ.push_back(expected);
    actQ.push_back(got);
    nameQ.push_back(currentTest);
    txnCount++;
  endtask

  task automatic doOp(input aluOpT op, input logic unsign, input wordT a, input wordT b);
    runTxn('{op: op, unsign: unsign, a: a, b: b}, 0);
  endtask

  task automatic startTest(input string name);
    currentTest = name;
    errBase = errorCount;
    txnBase = txnCount;
  endtask

  task automatic endTest();
    wait (actQ.size() == 0);
    @(posedge clk);
    #1;
    testCount++;
    $display("[DONE] %s: %0d transactions, %0d errors", currentTest,
             txnCount - txnBase, errorCount - errBase);
  endtask

  initial begin
    execReqT     r;
    int unsigned ru;
    clk = 1'b0;
    rstN = 1'b0;
    req = 1'b0;
    execReq = '0;
    cycleCount = 0;
    errorCount = 0;
    txnCount = 0;
    testCount = 0;
    hiModel = '0;
    loModel = '0;
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;

    startTest("reset");
    if (ack !== 1'b0) begin
      errorCount++;
      $display("reset: ack is not low after reset");
    end
    doOp(OpMfhi, 1'b0, '0, '0);
    doOp(OpMflo, 1'b0, '0, '0);
    endTest();

    startTest("alu");
    doOp(OpAdd, 1'b0, 32'd5, 32'd7);
    doOp(OpAdd, 1'b0, '1, 32'd1);
    doOp(OpSub, 1'b0, 32'h1234, 32'h1234);
    doOp(OpSub, 1'b0, 32'hffff_fff0, 32'd5);  // Signed less.
    doOp(OpSub, 1'b1, 32'd5, 32'hffff_fff0);  // Unsigned less.
    doOp(OpSub, 1'b1, 32'hffff_fff0, 32'd5);
    doOp(OpAnd, 1'b0, 32'hf0f0_ff00, 32'h3c3c_0ff0);
    doOp(OpOr, 1'b0, 32'hf0f0_ff00, 32'h3c3c_0ff0);
    doOp(OpXor, 1'b0, 32'hf0f0_ff00, 32'h3c3c_0ff0);
    doOp(OpSlt, 1'b0, '1, 32'd1);
    doOp(OpSlt, 1'b1, '1, 32'd1);
    endTest();

    startTest("shift");
    doOp(OpSll, 1'b0, 32'd0, 32'h8765_4321);
    doOp(OpSll, 1'b0, 32'd31, 32'h8765_4321);
    doOp(OpSrl, 1'b0, 32'd31, 32'h8000_0000);
    doOp(OpSra, 1'b0, 32'd4, 32'hf000_0000);
    doOp(OpSra, 1'b0, 32'd31, 32'h8000_0000);
    doOp(OpSra, 1'b0, 32'd0, 32'h9000_0001);
    doOp(OpSll, 1'b0, 32'hffff_ffe3, 32'h0000_00ff);  // Only the low five bits count.
    doOp(OpSrl, 1'b0, 32'h0000_0120, 32'hdead_beef);
    endTest();

    startTest("mult");
    doOp(OpMult, 1'b0, 32'hffff_fffd, 32'd7);
    doOp(OpMult, 1'b1, '1, '1);
    doOp(OpMult, 1'b0, 32'h8000_0000, 32'h8000_0000);
    doOp(OpMult, 1'b0, 32'h8000_0000, '1);
    repeat (4) begin
      ru = nextRand();
      r = '{op: OpMult, unsign: ru[20], a: randWord(), b: randWord()};
      runTxn(r, 0);
      doOp(OpMfhi, 1'b0, '0, '0);
      doOp(OpMflo, 1'b0, '0, '0);
    end
    doOp(OpAdd, 1'b0, 32'd1, 32'd2);
    doOp(OpMfhi, 1'b0, '0, '0);
    doOp(OpMflo, 1'b0, '0, '0);
    endTest();

    startTest("div");
    doOp(OpDiv, 1'b0, -32'd7, 32'd2);
    doOp(OpDiv, 1'b0, 32'd7, -32'd2);
    doOp(OpDiv, 1'b0, -32'd7, -32'd2);
    doOp(OpDiv, 1'b1, 32'd7, 32'd2);
    doOp(OpDiv, 1'b1, '1, 32'd2);
    doOp(OpDiv, 1'b0, -32'd5, '0);
    doOp(OpDiv, 1'b0, 32'd5, '0);
    doOp(OpDiv, 1'b1, 32'd5, '0);
    doOp(OpDiv, 1'b0, 32'h8000_0000, '1);
    doOp(OpDiv, 1'b1, 32'h8000_0000, '1);
    doOp(OpMfhi, 1'b0, '0, '0);
    doOp(OpMflo, 1'b0, '0, '0);
    endTest();

    startTest("random");
    repeat (300) begin
      ru = nextRand();
      r.op = aluOpT'(4'(ru[31:16] % 16'd13));
      r.unsign = ru[20];
      r.a = randWord();
      r.b = randWord();
      runTxn(r, int'(ru[25:23]));  // Extra cycles of back-pressure.
    end
    endTest();

    $display("Summary: %0d tests, %0d transactions, %0d errors", testCount, txnCount, errorCount);
    if (errorCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mipsExec.f
+incdir+rtl
rtl/aluPkg.sv
rtl/execPkg.sv
rtl/mipsAlu.sv
rtl/mulDivUnit.sv
rtl/execUnit.sv
tests/execUnitTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mipsExec.f --top-module execUnitTb -o execUnitSim

# The log decides the outcome, so a nonzero simulator status is not fatal here.
./obj_dir/execUnitSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test passed" sim.log; then
  exit 0
else
  exit 1
fi
